/* list.f */
+incdir+.
mm_pkg.sv
processing_element.sv
systolic_array.sv
operand_skew.sv
mm_sequencer.sv
word_ram.sv
host_port.sv
matmul_top.sv
tb_clock.sv
tb_matmul.sv

/* Makefile */
SIM      = verilator
TOP      = tb_matmul
FILELIST = list.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
PASS_MSG = Simulation PASSED

.PHONY: compile run clean

compile:
	$(SIM) $(FLAGS) -f $(FILELIST)

# status comes from the search for the pass message
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_matmul.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module tb_matmul;

  localparam int N = `MM_MAT_SIZE;
  localparam int DONE_CYCLES = 21;
  localparam int NUM_RUNS = 7;
  // per run 40 cycles plus about 20 host accesses at 10 cycles each
  localparam int LIMIT_CYCLES = NUM_RUNS * (40 + 20 * 10) + 16 + 200;

  logic          clk;
  logic          reset;
  logic          enable_writing_to_mem;
  logic          enable_reading_from_mem;
  mm_pkg::addr_t addr_pi;
  mm_pkg::word_t data_pi;
  logic          we_a;
  logic          we_b;
  logic          start_mat_mul;
  mm_pkg::word_t data_from_out_mat;
  logic          done_mat_mul;

  logic [15:0] a_mat [N][N];
  logic [15:0] b_mat [N][N];
  logic [15:0] c_exp [N][N];
  logic [31:0] lfsr;
  int          prev_rd_addr;

  tb_clock u_clock (.clk(clk), .reset(reset));

  matmul_top UUT (
    .clk(clk),
    .reset(reset),
    .enable_writing_to_mem(enable_writing_to_mem),
    .enable_reading_from_mem(enable_reading_from_mem),
    .addr_pi(addr_pi),
    .data_pi(data_pi),
    .we_a(we_a),
    .we_b(we_b),
    .start_mat_mul(start_mat_mul),
    .data_from_out_mat(data_from_out_mat),
    .done_mat_mul(done_mat_mul)
  );

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [15:0] random_lane(input int nbits);
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < nbits; b++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[14:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                             input string what);
    if (actual !== expected) begin
      abort_run($sformatf("** Error at %0t ns: %s, got %0h, expected %0h",
                          $time, what, actual, expected));
    end
  endtask

  // sum of products wraps at 32 bits, then saturates to 16
  function automatic void compute_model();
    logic [31:0] sum;
    for (int i = 0; i < N; i++) begin
      for (int j = 0; j < N; j++) begin
        sum = '0;
        for (int k = 0; k < N; k++) begin
          sum = sum + 32'(a_mat[i][k]) * 32'(b_mat[k][j]);
        end
        c_exp[i][j] = (sum >= 32'd65536) ? 16'hffff : sum[15:0];
      end
    end
  endfunction

  task automatic fill_matrices(input int nbits, input bit wrap_case);
    for (int i = 0; i < N; i++) begin
      for (int k = 0; k < N; k++) begin
        if (wrap_case) begin
          a_mat[i][k] = 16'h8000;
          b_mat[i][k] = 16'h8000;
        end else begin
          a_mat[i][k] = random_lane(nbits);
          b_mat[i][k] = random_lane(nbits);
        end
      end
    end
  endtask

  task automatic write_word(input logic to_a, input int addr, input mm_pkg::word_t w);
    @(posedge clk);
    enable_writing_to_mem <= 1'b1;
    we_a <= to_a;
    we_b <= !to_a;
    addr_pi <= mm_pkg::addr_t'(addr);
    data_pi <= w;
  endtask

  task automatic release_host();
    @(posedge clk);
    enable_writing_to_mem <= 1'b0;
    enable_reading_from_mem <= 1'b0;
    we_a <= 1'b0;
    we_b <= 1'b0;
  endtask

  task automatic load_matrices();
    mm_pkg::word_t w;
    // A goes in by columns, B by rows
    for (int k = 0; k < N; k++) begin
      for (int i = 0; i < N; i++) begin
        w[i] = a_mat[i][k];
      end
      write_word(1'b1, k, w);
    end
    for (int k = 0; k < N; k++) begin
      for (int j = 0; j < N; j++) begin
        w[j] = b_mat[k][j];
      end
      write_word(1'b0, k, w);
    end
    release_host();
    repeat (2) @(posedge clk);
  endtask

  task automatic run_matmul(input int run, input bit attempt_writes);
    mm_pkg::word_t junk;
    int            cycles;
    cycles = 0;
    @(posedge clk);
    start_mat_mul <= 1'b1;
    // count from the edge that first samples start
    @(posedge clk);
    @(negedge clk);
    while (!done_mat_mul) begin
      if (cycles > 2 * DONE_CYCLES) begin
        abort_run($sformatf("run %0d: done never came after start went high", run));
      end
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end
    check_equal(64'(cycles), 64'(DONE_CYCLES), $sformatf("run %0d start to done", run));
    repeat (3) begin
      @(posedge clk);
      @(negedge clk);
      check_equal(64'(done_mat_mul), 64'd1, $sformatf("run %0d done held", run));
    end
    if (attempt_writes) begin
      // these must not reach A or B
      for (int k = 0; k < N; k++) begin
        for (int i = 0; i < N; i++) begin
          junk[i] = random_lane(16);
        end
        write_word(1'b1, k, junk);
        write_word(1'b0, k, junk);
      end
      release_host();
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_equal(64'(done_mat_mul), 64'd1, $sformatf("run %0d done after writes", run));
    end
    @(posedge clk);
    start_mat_mul <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    check_equal(64'(done_mat_mul), 64'd0, $sformatf("run %0d done after release", run));
  endtask

  task automatic check_row(input int run, input int row);
    for (int j = 0; j < N; j++) begin
      check_equal(64'(data_from_out_mat[j]), 64'(c_exp[row][j]),
                  $sformatf("run %0d C[%0d][%0d]", run, row, j));
    end
  endtask

  task automatic read_and_check(input int run);
    for (int r = 0; r < N; r++) begin
      @(posedge clk);
      enable_reading_from_mem <= 1'b1;
      addr_pi <= mm_pkg::addr_t'(r);
      @(posedge clk);
      enable_reading_from_mem <= 1'b0;
      @(negedge clk);
      // one cycle in, the previous row is still on the port
      check_row(run, prev_rd_addr);
      @(posedge clk);
      @(negedge clk);
      check_row(run, r);
      prev_rd_addr = r;
    end
  endtask

  task automatic run_case(input int run, input int nbits, input bit wrap_case,
                          input bit attempt_writes, input bit reload);
    if (reload) begin
      fill_matrices(nbits, wrap_case);
      compute_model();
      load_matrices();
    end
    run_matmul(run, attempt_writes);
    read_and_check(run);
  endtask

  initial begin
    repeat (LIMIT_CYCLES) @(posedge clk);
    abort_run("watchdog expired: done never came within the time allowed for all runs");
  end

  initial begin
    lfsr = 32'h1836_3417;
    prev_rd_addr = 0;
    enable_writing_to_mem = 1'b0;
    enable_reading_from_mem = 1'b0;
    addr_pi = '0;
    data_pi = '0;
    we_a = 1'b0;
    we_b = 1'b0;
    start_mat_mul = 1'b0;
    @(negedge reset);
    @(posedge clk);
    run_case(0, 8, 1'b0, 1'b0, 1'b1);
    run_case(1, 16, 1'b0, 1'b0, 1'b1);
    // all lanes 0x8000, every sum wraps to zero
    run_case(2, 16, 1'b1, 1'b0, 1'b1);
    run_case(3, 8, 1'b0, 1'b1, 1'b1);
    // same A and B as run 3, so same results
    run_case(4, 8, 1'b0, 1'b0, 1'b0);
    run_case(5, 9, 1'b0, 1'b0, 1'b1);
    run_case(6, 16, 1'b0, 1'b0, 1'b1);
    repeat (2) @(posedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ns

module tb_clock (
  output logic clk,
  output logic reset
);

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset held for the first 16 rising edges
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

/* matmul_top.sv */
`timescale 1ns/1ns

module matmul_top (
  input  logic          clk,
  input  logic          reset,
  input  logic          enable_writing_to_mem,
  input  logic          enable_reading_from_mem,
  input  mm_pkg::addr_t addr_pi,
  input  mm_pkg::word_t data_pi,
  input  logic          we_a,
  input  logic          we_b,
  input  logic          start_mat_mul,
  output mm_pkg::word_t data_from_out_mat,
  output logic          done_mat_mul
);

  mm_pkg::host_req_t req;
  mm_pkg::addr_t     a_addr;
  mm_pkg::addr_t     b_addr;
  mm_pkg::addr_t     c_mem_addr;
  logic              a_we;
  logic              b_we;
  logic              c_mem_we;
  mm_pkg::word_t     wr_data;
  mm_pkg::word_t     a_q;
  mm_pkg::word_t     b_q;
  mm_pkg::addr_t     feed_addr;
  logic              feed_valid;
  logic              clear;
  logic              acc_en;
  logic [1:0]        row_sel;
  logic              c_we;
  mm_pkg::addr_t     c_addr;
  mm_pkg::word_t     a_lanes;
  mm_pkg::word_t     b_lanes;
  mm_pkg::word_t     c_row;

  assign req = '{
    wr_en: enable_writing_to_mem,
    rd_en: enable_reading_from_mem,
    we_a:  we_a,
    we_b:  we_b,
    addr:  addr_pi,
    data:  data_pi
  };

  host_port u_host_port (
    .clk(clk), .reset(reset), .req(req), .running(start_mat_mul),
    .feed_addr(feed_addr), .c_we(c_we), .c_addr(c_addr),
    .a_addr(a_addr), .b_addr(b_addr), .c_mem_addr(c_mem_addr),
    .a_we(a_we), .b_we(b_we), .c_mem_we(c_mem_we), .wr_data(wr_data)
  );

  word_ram u_mem_a (.clk(clk), .addr(a_addr), .we(a_we), .d(wr_data), .q(a_q));
  word_ram u_mem_b (.clk(clk), .addr(b_addr), .we(b_we), .d(wr_data), .q(b_q));
  word_ram u_mem_c (
    .clk(clk), .addr(c_mem_addr), .we(c_mem_we), .d(c_row), .q(data_from_out_mat)
  );

  mm_sequencer u_seq (
    .clk(clk), .reset(reset), .start(start_mat_mul),
    .feed_addr(feed_addr), .feed_valid(feed_valid), .clear(clear), .acc_en(acc_en),
    .row_sel(row_sel), .c_we(c_we), .c_addr(c_addr), .done(done_mat_mul)
  );

  // A enters the rows, B enters the columns
  operand_skew u_skew_a (
    .clk(clk), .reset(reset), .clear(clear), .valid(feed_valid), .word(a_q), .lanes(a_lanes)
  );
  operand_skew u_skew_b (
    .clk(clk), .reset(reset), .clear(clear), .valid(feed_valid), .word(b_q), .lanes(b_lanes)
  );

  systolic_array u_array (
    .clk(clk), .reset(reset), .clear(clear), .acc_en(acc_en),
    .a_lanes(a_lanes), .b_lanes(b_lanes), .row_sel(row_sel), .c_row(c_row)
  );

endmodule

/* host_port.sv */
`timescale 1ns/1ns

module host_port (
  input  logic              clk,
  input  logic              reset,
  input  mm_pkg::host_req_t req,
  input  logic              running,
  input  mm_pkg::addr_t     feed_addr,
  input  logic              c_we,
  input  mm_pkg::addr_t     c_addr,
  output mm_pkg::addr_t     a_addr,
  output mm_pkg::addr_t     b_addr,
  output mm_pkg::addr_t     c_mem_addr,
  output logic              a_we,
  output logic              b_we,
  output logic              c_mem_we,
  output mm_pkg::word_t     wr_data
);

  mm_pkg::host_req_t req_q;
  mm_pkg::addr_t     c_rd_addr;

  // address, data and strobes move together, one stage
  always_ff @(posedge clk) begin
    if (reset) begin
      req_q <= '0;
    end else begin
      req_q <= req;
    end
  end

  // last host read address, held so the C output stays put between reads
  always_ff @(posedge clk) begin
    if (reset) begin
      c_rd_addr <= '0;
    end else if (req.rd_en && !running) begin
      c_rd_addr <= req.addr;
    end
  end

  // sequencer owns all three memories during a run
  assign a_addr  = running ? feed_addr : req_q.addr;
  assign b_addr  = running ? feed_addr : req_q.addr;
  assign a_we    = !running && req_q.wr_en && req_q.we_a;
  assign b_we    = !running && req_q.wr_en && req_q.we_b;
  assign wr_data = req_q.data;

  assign c_mem_addr = running ? c_addr : c_rd_addr;
  assign c_mem_we   = running && c_we;

  // a host write to A or B always carries a known word
  a_host_write_known : assert property (
    @(posedge clk) disable iff (reset)
    (a_we || b_we) |-> !$isunknown(wr_data)
  );

endmodule

/* word_ram.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module word_ram (
  input  logic          clk,
  input  mm_pkg::addr_t addr,
  input  logic          we,
  input  mm_pkg::word_t d,
  output mm_pkg::word_t q
);

  mm_pkg::word_t mem [`MM_MEM_SIZE];

  // read returns the old word when the same address is written
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= d;
    end
    q <= mem[addr];
  end

  a_write_addr_known : assert property (
    @(posedge clk) we |-> !$isunknown(addr)
  );

endmodule

/* mm_sequencer.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module mm_sequencer (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  output mm_pkg::addr_t     feed_addr,
  output logic              feed_valid,
  output logic              clear,
  output logic              acc_en,
  output logic [1:0]        row_sel,
  output logic              c_we,
  output mm_pkg::addr_t     c_addr,
  output logic              done
);

  mm_pkg::mm_state_e state;
  mm_pkg::mm_state_e state_next;
  logic [4:0]        cnt;
  logic              rd_window;

  always_comb begin
    state_next = state;
    case (state)
      mm_pkg::IDLE: begin
        if (start) begin
          state_next = mm_pkg::FEED;
        end
      end
      mm_pkg::FEED: begin
        if (cnt == 5'(`MM_DRAIN_START - 1)) begin
          state_next = mm_pkg::DRAIN;
        end
      end
      mm_pkg::DRAIN: begin
        if (cnt == 5'(`MM_DONE_COUNT - 1)) begin
          state_next = mm_pkg::DONE;
        end
      end
      mm_pkg::DONE: begin
        state_next = mm_pkg::DONE;
      end
      default: begin
        state_next = mm_pkg::IDLE;
      end
    endcase
    // dropping start aborts or ends the run
    if (!start) begin
      state_next = mm_pkg::IDLE;
    end
  end

  // counter reads 0 in the first cycle of FEED, parks at the done count
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= mm_pkg::IDLE;
      cnt   <= '0;
    end else begin
      state <= state_next;
      if (state == mm_pkg::IDLE || state_next == mm_pkg::IDLE) begin
        cnt <= '0;
      end else if (state != mm_pkg::DONE) begin
        cnt <= cnt + 5'd1;
      end
    end
  end

  // words 0 to 3 of A and B
  assign rd_window = (state == mm_pkg::FEED) && (cnt < 5'(`MM_MAT_SIZE));
  assign feed_addr = rd_window ? mm_pkg::addr_t'(cnt) : '0;

  // memory read latency is one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      feed_valid <= 1'b0;
    end else begin
      feed_valid <= rd_window;
    end
  end

  assign clear  = !start || (state == mm_pkg::IDLE);
  assign acc_en = (state == mm_pkg::FEED);

  // one C row per cycle
  assign row_sel = 2'(cnt - 5'(`MM_DRAIN_START));
  assign c_we    = (state == mm_pkg::DRAIN) && (cnt < 5'(`MM_DRAIN_START + `MM_MAT_SIZE));
  assign c_addr  = mm_pkg::addr_t'(row_sel);

  assign done = (state == mm_pkg::DONE);

  a_done_follows_start : assert property (
    @(posedge clk) disable iff (reset)
    !start |=> !done
  );

endmodule

/* operand_skew.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module operand_skew (
  input  logic          clk,
  input  logic          reset,
  input  logic          clear,
  input  logic          valid,
  input  mm_pkg::word_t word,
  output mm_pkg::word_t lanes
);

  mm_pkg::word_t entry;

  // zeros outside the four real words
  assign entry = valid ? word : '0;

  genvar i;
  generate
    for (i = 0; i < `MM_MAT_SIZE; i++) begin : g_lane
      if (i == 0) begin : g_direct
        assign lanes[i] = entry[i];
      end else begin : g_delay
        // lane i waits i cycles
        mm_pkg::lane_t pipe [i];

        always_ff @(posedge clk) begin
          if (reset || clear) begin
            for (int k = 0; k < i; k++) begin
              pipe[k] <= '0;
            end
          end else begin
            pipe[0] <= entry[i];
            for (int k = 1; k < i; k++) begin
              pipe[k] <= pipe[k-1];
            end
          end
        end

        assign lanes[i] = pipe[i-1];
      end
    end
  endgenerate

endmodule

/* systolic_array.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module systolic_array (
  input  logic          clk,
  input  logic          reset,
  input  logic          clear,
  input  logic          acc_en,
  input  mm_pkg::word_t a_lanes,
  input  mm_pkg::word_t b_lanes,
  input  logic [1:0]    row_sel,
  output mm_pkg::word_t c_row
);

  // a_link[i][j] feeds PE(i,j) from the left, b_link[i][j] from above
  mm_pkg::lane_t        a_link [`MM_MAT_SIZE][`MM_MAT_SIZE+1];
  mm_pkg::lane_t        b_link [`MM_MAT_SIZE+1][`MM_MAT_SIZE];
  mm_pkg::result_grid_t grid;

  genvar i, j;
  generate
    for (i = 0; i < `MM_MAT_SIZE; i++) begin : g_row
      // array edges take the skewed lanes
      assign a_link[i][0] = a_lanes[i];
      assign b_link[0][i] = b_lanes[i];

      for (j = 0; j < `MM_MAT_SIZE; j++) begin : g_col
        processing_element u_pe (
          .clk(clk),
          .reset(reset),
          .clear(clear),
          .acc_en(acc_en),
          .in_a(a_link[i][j]),
          .in_b(b_link[i][j]),
          .out_a(a_link[i][j+1]),
          .out_b(b_link[i+1][j]),
          .out_c(grid[i*`MM_MAT_SIZE + j])
        );
      end
    end
  endgenerate

  // right and bottom edge outputs run off the array
  always_comb begin
    for (int n = 0; n < `MM_MAT_SIZE; n++) begin
      c_row[n] = grid[{row_sel, n[1:0]}];
    end
  end

endmodule

/* processing_element.sv */
`timescale 1ns/1ns
`include "mm_defines.svh"

module processing_element (
  input  logic          clk,
  input  logic          reset,
  input  logic          clear,
  input  logic          acc_en,
  input  mm_pkg::lane_t in_a,
  input  mm_pkg::lane_t in_b,
  output mm_pkg::lane_t out_a,
  output mm_pkg::lane_t out_b,
  output mm_pkg::lane_t out_c
);

  mm_pkg::acc_t acc;
  mm_pkg::acc_t product;

  assign product = mm_pkg::acc_t'(in_a) * mm_pkg::acc_t'(in_b);

  // operands move one cell per cycle
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      out_a <= '0;
      out_b <= '0;
    end else begin
      out_a <= in_a;
      out_b <= in_b;
    end
  end

  // sum wraps, no overflow flag
  always_ff @(posedge clk) begin
    if (reset || clear) begin
      acc <= '0;
    end else if (acc_en) begin
      acc <= acc + product;
    end
  end

  // saturate to all ones if anything is left in the upper half
  assign out_c = (|acc[2*`MM_DWIDTH-1:`MM_DWIDTH]) ? '1 : acc[`MM_DWIDTH-1:0];

endmodule

/* mm_pkg.sv */
`include "mm_defines.svh"

package mm_pkg;

  // one operand or result lane
  typedef logic [`MM_DWIDTH-1:0] lane_t;

  // lane 0 sits in the low bits
  typedef lane_t [`MM_MAT_SIZE-1:0] word_t;

  typedef logic [`MM_AWIDTH-1:0] addr_t;

  // full product sum, wraps modulo 2^32
  typedef logic [2*`MM_DWIDTH-1:0] acc_t;

  // host access as seen on the top-level pins
  typedef struct packed {
    logic  wr_en;
    logic  rd_en;
    logic  we_a;
    logic  we_b;
    addr_t addr;
    word_t data;
  } host_req_t;

  typedef enum logic [1:0] {
    IDLE,
    FEED,
    DRAIN,
    DONE
  } mm_state_e;

  // saturated results, row i at entries 4*i to 4*i+3
  typedef lane_t [`MM_MAT_SIZE*`MM_MAT_SIZE-1:0] result_grid_t;

endpackage

/* mm_defines.svh */
`ifndef MM_DEFINES_SVH
`define MM_DEFINES_SVH

// lane and memory geometry
`define MM_DWIDTH 16
`define MM_AWIDTH 7
`define MM_MEM_SIZE 128

// array is square, one lane per row or column
`define MM_MAT_SIZE 4

// sequencer counter values
`define MM_DRAIN_START 16
`define MM_DONE_COUNT 21

`endif
